/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

   // major opcodes, bits [6:0] of the instruction word
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      SYSTEM = 7'b1110011
   } opcode_e;

   // operations the execute ALU knows
   typedef enum logic [2:0] {
      ADD    = 3'd0,
      SUB    = 3'd1,
      AND    = 3'd2,
      OR     = 3'd3,
      XOR    = 3'd4,
      SLT    = 3'd5,
      PASS_B = 3'd6
   } alu_op_e;

   // funct3 codes
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;
   localparam logic [2:0] F3_LW_SW   = 3'b010;

endpackage

`default_nettype wire

/* design/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

   // data and address width
   localparam int XLEN = 32;

   // register index width, 32 registers
   localparam int REG_AW = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // addi x0, x0, 0
   localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                imem_we_i,
   input  logic [$clog2(IMEM_WORDS)-1:0]       imem_addr_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]        imem_data_i,
   input  logic                                stall_i,
   input  logic                                redirect_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]        target_i,
   input  logic                                halted_i,
   output logic [rv_pipe_pkg::XLEN-1:0]        instr_o,
   output logic [rv_pipe_pkg::XLEN-1:0]        pc_o,
   output logic                                valid_o
);

   localparam int IMEM_AW = $clog2(IMEM_WORDS);

   logic [rv_pipe_pkg::XLEN-1:0] imem [IMEM_WORDS];
   logic [rv_pipe_pkg::XLEN-1:0] pc_q;

   // program load port, only open while the core is held in reset
   always_ff @(posedge clk) begin
      if (reset && imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q    <= rv_pipe_pkg::RESET_PC;
         instr_o <= rv_pipe_pkg::NOP_INSTR;
         valid_o <= 1'b0;
      end else if (redirect_i) begin
         // younger instruction in flight is dropped
         pc_q    <= target_i;
         instr_o <= rv_pipe_pkg::NOP_INSTR;
         valid_o <= 1'b0;
      end else if (halted_i) begin
         instr_o <= rv_pipe_pkg::NOP_INSTR;
         valid_o <= 1'b0;
      end else if (!stall_i) begin
         instr_o <= imem[pc_q[IMEM_AW+1:2]];
         pc_o    <= pc_q;
         valid_o <= 1'b1;
         pc_q    <= pc_q + 32'd4;
      end
   end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`default_nettype none

module decode_stage (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [rv_pipe_pkg::XLEN-1:0]       instr_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       pc_i,
   input  logic                               valid_i,
   input  logic                               flush_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     ex_rd_i,
   input  logic                               ex_load_i,
   input  logic                               wb_valid_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     wb_rd_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       wb_data_i,
   output logic                               stall_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       pc_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       rs1_data_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       rs2_data_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     rs1_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     rs2_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     rd_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       imm_o,
   output rv_isa_pkg::alu_op_e                alu_op_o,
   output logic                               reg_we_o,
   output logic                               load_o,
   output logic                               store_o,
   output logic                               beq_o,
   output logic                               bne_o,
   output logic                               jump_o,
   output logic                               halt_o,
   output logic                               valid_o
);

   rv_isa_pkg::opcode_e                opcode;
   rv_isa_pkg::alu_op_e                alu_op;
   logic [2:0]                         funct3;
   logic [rv_pipe_pkg::REG_AW-1:0]     rs1;
   logic [rv_pipe_pkg::REG_AW-1:0]     rs2;
   logic [rv_pipe_pkg::XLEN-1:0]       imm;
   logic [rv_pipe_pkg::XLEN-1:0]       imm_i_type;
   logic [rv_pipe_pkg::XLEN-1:0]       imm_s_type;
   logic [rv_pipe_pkg::XLEN-1:0]       imm_b_type;
   logic [rv_pipe_pkg::XLEN-1:0]       imm_u_type;
   logic [rv_pipe_pkg::XLEN-1:0]       imm_j_type;
   logic [rv_pipe_pkg::XLEN-1:0]       rs1_val;
   logic [rv_pipe_pkg::XLEN-1:0]       rs2_val;
   logic                               uses_rs1;
   logic                               uses_rs2;
   logic                               reg_we;
   logic                               load;
   logic                               store;
   logic                               beq;
   logic                               bne;
   logic                               jump;
   logic                               halt;

   logic [rv_pipe_pkg::XLEN-1:0] regs [32];

   assign opcode = rv_isa_pkg::opcode_e'(instr_i[6:0]);
   assign funct3 = instr_i[14:12];
   assign rs1    = instr_i[19:15];
   assign rs2    = instr_i[24:20];

   assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
   assign imm_u_type = {instr_i[31:12], 12'b0};
   assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

   always_comb begin
      alu_op   = rv_isa_pkg::ADD;
      imm      = imm_i_type;
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
      reg_we   = 1'b0;
      load     = 1'b0;
      store    = 1'b0;
      beq      = 1'b0;
      bne      = 1'b0;
      jump     = 1'b0;
      halt     = 1'b0;
      case (opcode)
         rv_isa_pkg::OP: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            reg_we   = 1'b1;
            case (funct3)
               rv_isa_pkg::F3_ADD_SUB: alu_op = instr_i[30] ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
               rv_isa_pkg::F3_XOR:     alu_op = rv_isa_pkg::XOR;
               rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::OR;
               rv_isa_pkg::F3_AND:     alu_op = rv_isa_pkg::AND;
               rv_isa_pkg::F3_SLT:     alu_op = rv_isa_pkg::SLT;
               default:                reg_we = 1'b0;
            endcase
         end
         rv_isa_pkg::OP_IMM: begin
            uses_rs1 = 1'b1;
            reg_we   = (funct3 == rv_isa_pkg::F3_ADD_SUB);
         end
         rv_isa_pkg::LUI: begin
            alu_op = rv_isa_pkg::PASS_B;
            imm    = imm_u_type;
            reg_we = 1'b1;
         end
         rv_isa_pkg::LOAD: begin
            uses_rs1 = 1'b1;
            reg_we   = (funct3 == rv_isa_pkg::F3_LW_SW);
            load     = (funct3 == rv_isa_pkg::F3_LW_SW);
         end
         rv_isa_pkg::STORE: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            imm      = imm_s_type;
            store    = (funct3 == rv_isa_pkg::F3_LW_SW);
         end
         rv_isa_pkg::BRANCH: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            imm      = imm_b_type;
            beq      = (funct3 == rv_isa_pkg::F3_BEQ);
            bne      = (funct3 == rv_isa_pkg::F3_BNE);
         end
         rv_isa_pkg::JAL: begin
            imm    = imm_j_type;
            reg_we = 1'b1;
            jump   = 1'b1;
         end
         rv_isa_pkg::SYSTEM: begin
            halt = (instr_i[31:20] == 12'd1) && (funct3 == 3'b000);
         end
         default: begin
            reg_we = 1'b0;
         end
      endcase
   end

   // register file, written from writeback and bypassed in the same cycle
   always_ff @(posedge clk) begin
      if (wb_valid_i) begin
         regs[wb_rd_i] <= wb_data_i;
      end
   end

   assign rs1_val = (rs1 == '0) ? '0 :
                    (wb_valid_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 :
                    (wb_valid_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

   // load in execute feeds this instruction, hold one cycle
   assign stall_o = valid_i && ex_load_i && (ex_rd_i != '0) &&
                    ((uses_rs1 && ex_rd_i == rs1) || (uses_rs2 && ex_rd_i == rs2));

   always_ff @(posedge clk) begin
      if (reset || flush_i || stall_o) begin
         valid_o  <= 1'b0;
         reg_we_o <= 1'b0;
         load_o   <= 1'b0;
         store_o  <= 1'b0;
         beq_o    <= 1'b0;
         bne_o    <= 1'b0;
         jump_o   <= 1'b0;
         halt_o   <= 1'b0;
      end else begin
         valid_o  <= valid_i;
         reg_we_o <= valid_i && reg_we && (instr_i[11:7] != '0);
         load_o   <= valid_i && load;
         store_o  <= valid_i && store;
         beq_o    <= valid_i && beq;
         bne_o    <= valid_i && bne;
         jump_o   <= valid_i && jump;
         halt_o   <= valid_i && halt;
      end
   end

   // when rs2 is unused the immediate rides in its slot as operand b
   always_ff @(posedge clk) begin
      pc_o       <= pc_i;
      rs1_o      <= uses_rs1 ? rs1 : '0;
      rs2_o      <= uses_rs2 ? rs2 : '0;
      rs1_data_o <= uses_rs1 ? rs1_val : '0;
      rs2_data_o <= uses_rs2 ? rs2_val : imm;
      rd_o       <= instr_i[11:7];
      imm_o      <= imm;
      alu_op_o   <= alu_op;
   end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`default_nettype none

module execute_stage (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [rv_pipe_pkg::XLEN-1:0]       pc_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       rs1_data_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       rs2_data_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     rs1_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     rs2_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     rd_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       imm_i,
   input  rv_isa_pkg::alu_op_e                alu_op_i,
   input  logic                               reg_we_i,
   input  logic                               load_i,
   input  logic                               store_i,
   input  logic                               beq_i,
   input  logic                               bne_i,
   input  logic                               jump_i,
   input  logic                               halt_i,
   input  logic                               valid_i,
   input  logic                               wb_valid_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     wb_rd_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       wb_data_i,
   output logic                               redirect_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       target_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     ex_rd_o,
   output logic                               ex_load_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       result_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       store_data_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     rd_o,
   output logic                               reg_we_o,
   output logic                               load_o,
   output logic                               store_o,
   output logic                               halt_o,
   output logic                               valid_o
);

   logic [rv_pipe_pkg::XLEN-1:0] op_a;
   logic [rv_pipe_pkg::XLEN-1:0] op_b;
   logic [rv_pipe_pkg::XLEN-1:0] alu_b;
   logic [rv_pipe_pkg::XLEN-1:0] alu_out;
   logic                         fwd_a_ex;
   logic                         fwd_b_ex;
   logic                         fwd_a_wb;
   logic                         fwd_b_wb;
   logic                         equal;

   // newest first: own previous result, then writeback, then register value
   assign fwd_a_ex = reg_we_o && !load_o && (rd_o != '0) && (rd_o == rs1_i);
   assign fwd_b_ex = reg_we_o && !load_o && (rd_o != '0) && (rd_o == rs2_i);
   assign fwd_a_wb = wb_valid_i && (wb_rd_i == rs1_i);
   assign fwd_b_wb = wb_valid_i && (wb_rd_i == rs2_i);

   assign op_a = fwd_a_ex ? result_o : fwd_a_wb ? wb_data_i : rs1_data_i;
   assign op_b = fwd_b_ex ? result_o : fwd_b_wb ? wb_data_i : rs2_data_i;

   // stores keep rs2 as data, address uses the immediate
   assign alu_b = store_i ? imm_i : op_b;

   always_comb begin
      case (alu_op_i)
         rv_isa_pkg::ADD:    alu_out = op_a + alu_b;
         rv_isa_pkg::SUB:    alu_out = op_a - alu_b;
         rv_isa_pkg::AND:    alu_out = op_a & alu_b;
         rv_isa_pkg::OR:     alu_out = op_a | alu_b;
         rv_isa_pkg::XOR:    alu_out = op_a ^ alu_b;
         rv_isa_pkg::SLT:    alu_out = {{(rv_pipe_pkg::XLEN-1){1'b0}},
                                        $signed(op_a) < $signed(alu_b)};
         rv_isa_pkg::PASS_B: alu_out = alu_b;
         default:            alu_out = op_a + alu_b;
      endcase
   end

   assign equal      = (op_a == op_b);
   assign redirect_o = jump_i || (beq_i && equal) || (bne_i && !equal);
   assign target_o   = pc_i + imm_i;

   // load-use check in decode
   assign ex_rd_o   = rd_i;
   assign ex_load_o = load_i;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_o  <= 1'b0;
         reg_we_o <= 1'b0;
         load_o   <= 1'b0;
         store_o  <= 1'b0;
         halt_o   <= 1'b0;
      end else begin
         valid_o  <= valid_i;
         reg_we_o <= reg_we_i;
         load_o   <= load_i;
         store_o  <= store_i;
         halt_o   <= halt_i;
      end
   end

   always_ff @(posedge clk) begin
      result_o     <= jump_i ? pc_i + 32'd4 : alu_out;
      store_data_o <= op_b;
      rd_o         <= rd_i;
   end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
`default_nettype none

module memory_stage #(
   parameter int DMEM_WORDS = 256
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [rv_pipe_pkg::XLEN-1:0]       result_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       store_data_i,
   input  logic [rv_pipe_pkg::REG_AW-1:0]     rd_i,
   input  logic                               reg_we_i,
   input  logic                               load_i,
   input  logic                               store_i,
   input  logic                               halt_i,
   input  logic                               valid_i,
   output logic                               wb_valid_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     wb_rd_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       wb_data_o,
   output logic                               halted_o
);

   localparam int DMEM_AW = $clog2(DMEM_WORDS);

   logic [rv_pipe_pkg::XLEN-1:0] dmem [DMEM_WORDS];
   logic [DMEM_AW-1:0]           dmem_idx;
   logic [rv_pipe_pkg::XLEN-1:0] load_data;

   initial begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = '0;
      end
   end

   // word address, low two bits ignored
   assign dmem_idx  = result_i[DMEM_AW+1:2];
   assign load_data = dmem[dmem_idx];

   always_ff @(posedge clk) begin
      if (valid_i && store_i && !halted_o) begin
         dmem[dmem_idx] <= store_data_i;
      end
   end

   // nothing behind ebreak may retire
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_valid_o <= 1'b0;
         halted_o   <= 1'b0;
      end else begin
         wb_valid_o <= valid_i && reg_we_i && (rd_i != '0) && !halted_o;
         halted_o   <= halted_o || (valid_i && halt_i);
      end
   end

   always_ff @(posedge clk) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= load_i ? load_data : result_i;
   end

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
`default_nettype none

module rv_core_top #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               imem_we_i,
   input  logic [$clog2(IMEM_WORDS)-1:0]      imem_addr_i,
   input  logic [rv_pipe_pkg::XLEN-1:0]       imem_data_i,
   output logic                               wb_valid_o,
   output logic [rv_pipe_pkg::REG_AW-1:0]     wb_rd_o,
   output logic [rv_pipe_pkg::XLEN-1:0]       wb_data_o,
   output logic                               halted_o
);

   // fetch to decode
   logic [rv_pipe_pkg::XLEN-1:0]   fd_instr;
   logic [rv_pipe_pkg::XLEN-1:0]   fd_pc;
   logic                           fd_valid;
   logic                           stall;

   // decode to execute
   logic [rv_pipe_pkg::XLEN-1:0]   de_pc;
   logic [rv_pipe_pkg::XLEN-1:0]   de_rs1_data;
   logic [rv_pipe_pkg::XLEN-1:0]   de_rs2_data;
   logic [rv_pipe_pkg::REG_AW-1:0] de_rs1;
   logic [rv_pipe_pkg::REG_AW-1:0] de_rs2;
   logic [rv_pipe_pkg::REG_AW-1:0] de_rd;
   logic [rv_pipe_pkg::XLEN-1:0]   de_imm;
   rv_isa_pkg::alu_op_e            de_alu_op;
   logic                           de_reg_we;
   logic                           de_load;
   logic                           de_store;
   logic                           de_beq;
   logic                           de_bne;
   logic                           de_jump;
   logic                           de_halt;
   logic                           de_valid;

   // execute feedback and execute to memory
   logic                           redirect;
   logic [rv_pipe_pkg::XLEN-1:0]   target;
   logic [rv_pipe_pkg::REG_AW-1:0] ex_rd;
   logic                           ex_load;
   logic [rv_pipe_pkg::XLEN-1:0]   em_result;
   logic [rv_pipe_pkg::XLEN-1:0]   em_store_data;
   logic [rv_pipe_pkg::REG_AW-1:0] em_rd;
   logic                           em_reg_we;
   logic                           em_load;
   logic                           em_store;
   logic                           em_halt;
   logic                           em_valid;

   fetch_stage #(
      .IMEM_WORDS(IMEM_WORDS)
   ) u_fetch (
      .clk(clk),
      .reset(reset),
      .imem_we_i(imem_we_i),
      .imem_addr_i(imem_addr_i),
      .imem_data_i(imem_data_i),
      .stall_i(stall),
      .redirect_i(redirect),
      .target_i(target),
      .halted_i(halted_o),
      .instr_o(fd_instr),
      .pc_o(fd_pc),
      .valid_o(fd_valid)
   );

   // redirect doubles as the decode flush
   decode_stage u_decode (
      .clk(clk),
      .reset(reset),
      .instr_i(fd_instr),
      .pc_i(fd_pc),
      .valid_i(fd_valid),
      .flush_i(redirect),
      .ex_rd_i(ex_rd),
      .ex_load_i(ex_load),
      .wb_valid_i(wb_valid_o),
      .wb_rd_i(wb_rd_o),
      .wb_data_i(wb_data_o),
      .stall_o(stall),
      .pc_o(de_pc),
      .rs1_data_o(de_rs1_data),
      .rs2_data_o(de_rs2_data),
      .rs1_o(de_rs1),
      .rs2_o(de_rs2),
      .rd_o(de_rd),
      .imm_o(de_imm),
      .alu_op_o(de_alu_op),
      .reg_we_o(de_reg_we),
      .load_o(de_load),
      .store_o(de_store),
      .beq_o(de_beq),
      .bne_o(de_bne),
      .jump_o(de_jump),
      .halt_o(de_halt),
      .valid_o(de_valid)
   );

   execute_stage u_execute (
      .clk(clk),
      .reset(reset),
      .pc_i(de_pc),
      .rs1_data_i(de_rs1_data),
      .rs2_data_i(de_rs2_data),
      .rs1_i(de_rs1),
      .rs2_i(de_rs2),
      .rd_i(de_rd),
      .imm_i(de_imm),
      .alu_op_i(de_alu_op),
      .reg_we_i(de_reg_we),
      .load_i(de_load),
      .store_i(de_store),
      .beq_i(de_beq),
      .bne_i(de_bne),
      .jump_i(de_jump),
      .halt_i(de_halt),
      .valid_i(de_valid),
      .wb_valid_i(wb_valid_o),
      .wb_rd_i(wb_rd_o),
      .wb_data_i(wb_data_o),
      .redirect_o(redirect),
      .target_o(target),
      .ex_rd_o(ex_rd),
      .ex_load_o(ex_load),
      .result_o(em_result),
      .store_data_o(em_store_data),
      .rd_o(em_rd),
      .reg_we_o(em_reg_we),
      .load_o(em_load),
      .store_o(em_store),
      .halt_o(em_halt),
      .valid_o(em_valid)
   );

   memory_stage #(
      .DMEM_WORDS(DMEM_WORDS)
   ) u_memory (
      .clk(clk),
      .reset(reset),
      .result_i(em_result),
      .store_data_i(em_store_data),
      .rd_i(em_rd),
      .reg_we_i(em_reg_we),
      .load_i(em_load),
      .store_i(em_store),
      .halt_i(em_halt),
      .valid_i(em_valid),
      .wb_valid_o(wb_valid_o),
      .wb_rd_o(wb_rd_o),
      .wb_data_o(wb_data_o),
      .halted_o(halted_o)
   );

endmodule

`default_nettype wire

/* include/rv_tb_programs.svh */
`ifndef RV_TB_PROGRAMS_SVH
`define RV_TB_PROGRAMS_SVH

localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

// instruction encoders
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input rv_isa_pkg::opcode_e opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
   return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_LW_SW, imm[4:0], rv_isa_pkg::STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
   return {imm, rd, rv_isa_pkg::LUI};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::JAL};
endfunction

function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
   return i_type(imm, rs1, rv_isa_pkg::F3_ADD_SUB, rd, rv_isa_pkg::OP_IMM);
endfunction

task automatic reset_state_test();
   repeat (3) begin
      @(negedge clk);
      check_value("wb_valid_o in reset", {31'b0, wb_valid_o}, 32'd0);
      check_value("halted_o in reset", {31'b0, halted_o}, 32'd0);
   end
endtask

task automatic forwarding_test();
   logic [11:0] ia;
   logic [11:0] ib;
   logic [19:0] up;
   logic [31:0] x [11];
   ia = 12'(next_random());
   ib = 12'(next_random());
   up = 20'(next_random());
   x[1]  = {{20{ia[11]}}, ia};
   x[2]  = x[1] + {{20{ib[11]}}, ib};
   x[3]  = x[1] + x[2];
   x[4]  = x[3] - x[1];
   x[5]  = x[4] & x[1];
   x[6]  = x[5] | x[3];
   x[7]  = x[6] ^ x[4];
   x[8]  = ($signed(x[7]) < $signed(x[1])) ? 32'd1 : 32'd0;
   x[9]  = {up, 12'b0};
   x[10] = x[9] + x[8];
   prog.push_back(addi(5'd1, 5'd0, ia));
   prog.push_back(addi(5'd2, 5'd1, ib));
   prog.push_back(r_type(7'h00, 5'd2, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd3));
   prog.push_back(r_type(7'h20, 5'd1, 5'd3, rv_isa_pkg::F3_ADD_SUB, 5'd4));
   prog.push_back(r_type(7'h00, 5'd1, 5'd4, rv_isa_pkg::F3_AND, 5'd5));
   prog.push_back(r_type(7'h00, 5'd3, 5'd5, rv_isa_pkg::F3_OR, 5'd6));
   prog.push_back(r_type(7'h00, 5'd4, 5'd6, rv_isa_pkg::F3_XOR, 5'd7));
   prog.push_back(r_type(7'h00, 5'd1, 5'd7, rv_isa_pkg::F3_SLT, 5'd8));
   prog.push_back(u_type(up, 5'd9));
   prog.push_back(r_type(7'h00, 5'd8, 5'd9, rv_isa_pkg::F3_ADD_SUB, 5'd10));
   prog.push_back(EBREAK_INSTR);
   for (int r = 1; r <= 10; r++) begin
      expect_wb(5'(r), x[r]);
   end
   run_program("forwarding");
endtask

task automatic memory_test();
   logic [11:0] c;
   logic [31:0] cv;
   c  = 12'(next_random());
   cv = {{20{c[11]}}, c};
   prog.push_back(addi(5'd1, 5'd0, 12'd64));
   prog.push_back(addi(5'd2, 5'd0, c));
   prog.push_back(s_type(12'd8, 5'd2, 5'd1));
   prog.push_back(i_type(12'd8, 5'd1, rv_isa_pkg::F3_LW_SW, 5'd3, rv_isa_pkg::LOAD));
   prog.push_back(r_type(7'h00, 5'd2, 5'd3, rv_isa_pkg::F3_ADD_SUB, 5'd4));
   prog.push_back(i_type(12'd8, 5'd1, rv_isa_pkg::F3_LW_SW, 5'd5, rv_isa_pkg::LOAD));
   prog.push_back(addi(5'd6, 5'd5, 12'd1));
   prog.push_back(EBREAK_INSTR);
   expect_wb(5'd1, 32'd64);
   expect_wb(5'd2, cv);
   expect_wb(5'd3, cv);
   expect_wb(5'd4, cv + cv);
   expect_wb(5'd5, cv);
   expect_wb(5'd6, cv + 32'd1);
   run_program("memory");
endtask

task automatic branch_test();
   prog.push_back(addi(5'd1, 5'd0, 12'd5));
   prog.push_back(addi(5'd2, 5'd0, 12'd5));
   // taken beq skips two
   prog.push_back(b_type(13'd12, 5'd2, 5'd1, rv_isa_pkg::F3_BEQ));
   prog.push_back(addi(5'd3, 5'd0, 12'd1));
   prog.push_back(addi(5'd4, 5'd0, 12'd2));
   prog.push_back(b_type(13'd12, 5'd2, 5'd1, rv_isa_pkg::F3_BNE));
   prog.push_back(addi(5'd5, 5'd0, 12'd3));
   prog.push_back(addi(5'd6, 5'd0, 12'd4));
   prog.push_back(b_type(13'd12, 5'd5, 5'd1, rv_isa_pkg::F3_BNE));
   prog.push_back(addi(5'd7, 5'd0, 12'd7));
   prog.push_back(addi(5'd8, 5'd0, 12'd8));
   prog.push_back(b_type(13'd12, 5'd6, 5'd1, rv_isa_pkg::F3_BEQ));
   prog.push_back(addi(5'd9, 5'd0, 12'd9));
   prog.push_back(EBREAK_INSTR);
   expect_wb(5'd1, 32'd5);
   expect_wb(5'd2, 32'd5);
   expect_wb(5'd5, 32'd3);
   expect_wb(5'd6, 32'd4);
   expect_wb(5'd9, 32'd9);
   run_program("branch");
endtask

task automatic jump_test();
   prog.push_back(addi(5'd1, 5'd0, 12'd1));
   prog.push_back(j_type(21'd12, 5'd5));
   prog.push_back(addi(5'd2, 5'd0, 12'd2));
   prog.push_back(addi(5'd3, 5'd0, 12'd3));
   prog.push_back(j_type(21'd8, 5'd0));
   prog.push_back(addi(5'd4, 5'd0, 12'd4));
   prog.push_back(addi(5'd0, 5'd0, 12'd7));
   prog.push_back(r_type(7'h00, 5'd1, 5'd5, rv_isa_pkg::F3_ADD_SUB, 5'd6));
   prog.push_back(EBREAK_INSTR);
   expect_wb(5'd1, 32'd1);
   expect_wb(5'd5, 32'd8);
   expect_wb(5'd6, 32'd9);
   run_program("jump");
endtask

task automatic halt_test();
   prog.push_back(addi(5'd1, 5'd0, 12'd11));
   prog.push_back(EBREAK_INSTR);
   prog.push_back(addi(5'd2, 5'd0, 12'd22));
   prog.push_back(addi(5'd3, 5'd1, 12'd33));
   prog.push_back(addi(5'd4, 5'd0, 12'd44));
   expect_wb(5'd1, 32'd11);
   run_program("halt");
   check_value("halted_o after ebreak", {31'b0, halted_o}, 32'd1);
endtask

`endif

/* tb/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IMEM_WORDS = 256;
   localparam int DMEM_WORDS = 256;
   localparam int HALT_TIMEOUT = 200;

   logic        clk;
   logic        reset;
   logic        imem_we_i;
   logic [7:0]  imem_addr_i;
   logic [31:0] imem_data_i;
   logic        wb_valid_o;
   logic [4:0]  wb_rd_o;
   logic [31:0] wb_data_o;
   logic        halted_o;

   int          error_count;
   int          check_count;
   logic [31:0] rng_state;

   // program image and writeback records
   logic [31:0] prog [$];
   logic [4:0]  got_rd [$];
   logic [31:0] got_data [$];
   logic [4:0]  exp_rd [$];
   logic [31:0] exp_data [$];

   rv_core_top #(
      .IMEM_WORDS(IMEM_WORDS),
      .DMEM_WORDS(DMEM_WORDS)
   ) DUT (
      .clk(clk),
      .reset(reset),
      .imem_we_i(imem_we_i),
      .imem_addr_i(imem_addr_i),
      .imem_data_i(imem_data_i),
      .wb_valid_o(wb_valid_o),
      .wb_rd_o(wb_rd_o),
      .wb_data_o(wb_data_o),
      .halted_o(halted_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // writeback monitor samples mid-cycle
   always @(negedge clk) begin
      if (reset == 1'b0 && wb_valid_o === 1'b1) begin
         got_rd.push_back(wb_rd_o);
         got_data.push_back(wb_data_o);
      end
   end

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic expect_wb(input logic [4:0] rd, input logic [31:0] value);
      exp_rd.push_back(rd);
      exp_data.push_back(value);
   endtask

   // load prog while in reset, release, wait for halt and compare writebacks
   task automatic run_program(input string name);
      int cycles;
      int n;
      @(posedge clk);
      #2;
      reset = 1'b1;
      for (int i = 0; i < prog.size(); i++) begin
         imem_we_i   = 1'b1;
         imem_addr_i = 8'(i);
         imem_data_i = prog[i];
         @(posedge clk);
         #2;
      end
      imem_we_i = 1'b0;
      got_rd.delete();
      got_data.delete();
      repeat (3) begin
         @(posedge clk);
         #2;
      end
      reset = 1'b0;
      cycles = 0;
      while (halted_o !== 1'b1 && cycles < HALT_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (halted_o !== 1'b1) begin
         error_count++;
         $display("%s: halted_o did not rise within %0d cycles", name, HALT_TIMEOUT);
      end
      // let anything behind the ebreak drain
      repeat (6) @(negedge clk);
      check_value({name, " writeback count"}, 32'(got_rd.size()), 32'(exp_rd.size()));
      n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
      for (int i = 0; i < n; i++) begin
         check_value($sformatf("%s wb %0d rd", name, i), 32'(got_rd[i]), 32'(exp_rd[i]));
         check_value($sformatf("%s wb %0d data", name, i), got_data[i], exp_data[i]);
      end
      prog.delete();
      exp_rd.delete();
      exp_data.delete();
   endtask

   `include "rv_tb_programs.svh"

   initial begin
      reset       = 1'b1;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      error_count = 0;
      check_count = 0;
      rng_state   = 32'h00bf8a9d;

      reset_state_test();
      forwarding_test();
      memory_test();
      branch_test();
      jump_test();
      halt_test();

      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rv_pipe.f */
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core_top.sv
tb/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench and core with Verilator, run it, then scan the log

LOG=sim.log

verilator --binary --timing -f rv_pipe.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
exit 0
